//--- logic/ff_macros.svh
// Layer sizes and Q16.16 fixed-point format
// Word map of the shared memory
// Byte offsets of the control and status registers
`ifndef FF_MACROS_SVH
`define FF_MACROS_SVH

// Layer shape
`define FF_INPUTS      8
`define FF_NEURONS     4
`define FF_FRAC_BITS   16

// Shared memory, word addressed
`define FF_MEM_DEPTH   64
`define FF_IN_BASE     0
`define FF_BIAS_BASE   8
`define FF_ACT_BASE    12
// Weight of neuron n, input i at W_BASE + n*INPUTS + i
`define FF_W_BASE      16

// Registers above the memory window
`define FF_REG_CTRL    12'h100
`define FF_REG_STATUS  12'h104
`define FF_REG_GOOD    12'h108
`define FF_AXI_ADDR_W  12

`endif

//--- logic/ff_pkg.sv
// Shared types of the layer
// Data word, memory and bus addresses, bus responses
// Engine state encoding
`include "ff_macros.svh"

package ff_pkg;

    // One Q16.16 value
    typedef logic [31:0] ff_data_t;

    // Word index into the shared memory
    typedef logic [$clog2(`FF_MEM_DEPTH)-1:0] ff_word_addr_t;

    // Byte address on the AXI4-Lite bus
    typedef logic [`FF_AXI_ADDR_W-1:0] ff_axi_addr_t;

    // AXI response code
    typedef logic [1:0] ff_resp_t;

    localparam ff_resp_t RESP_OKAY   = 2'b00;
    localparam ff_resp_t RESP_SLVERR = 2'b10;

    // Per neuron: inputs and weights in pairs, then bias, then write back
    typedef enum logic [2:0] {
        IDLE, READ_IN, READ_W, READ_BIAS, WRITE_ACT, DONE
    } ff_engine_state_t;

endpackage

//--- logic/ff_axil_slave.sv
// AXI4-Lite slave of the layer
// Address decode into memory window, registers or error
// Memory accesses go through the arbiter as requester 0
// Control, status and goodness registers answered locally
`include "ff_macros.svh"

module ff_axil_slave import ff_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  ff_axi_addr_t  awaddr,
    input  logic          awvalid,
    output logic          awready,
    input  ff_data_t      wdata,
    // Byte strobes not supported, full word always written
    input  logic [3:0]    wstrb,
    input  logic          wvalid,
    output logic          wready,
    output ff_resp_t      bresp,
    output logic          bvalid,
    input  logic          bready,
    input  ff_axi_addr_t  araddr,
    input  logic          arvalid,
    output logic          arready,
    output ff_data_t      rdata,
    output ff_resp_t      rresp,
    output logic          rvalid,
    input  logic          rready,
    output logic          mem_req,
    output logic          mem_we,
    output ff_word_addr_t mem_addr,
    output ff_data_t      mem_wdata,
    input  logic          mem_gnt,
    input  ff_data_t      mem_rdata,
    output logic          start,
    input  logic          busy,
    input  logic          done,
    input  ff_data_t      goodness
);

    typedef enum logic [1:0] {SL_IDLE, SL_MEM, SL_MEM_DATA, SL_RESP} slv_state_t;

    slv_state_t   state;
    ff_axi_addr_t acc_addr;
    ff_axi_addr_t addr_q;
    ff_data_t     wdata_q;
    ff_data_t     rdata_q;
    ff_data_t     reg_rdata;
    ff_resp_t     resp_q;
    logic         we_q;
    logic         wr_accept;
    logic         rd_accept;
    logic         is_mem;
    logic         is_ctrl;
    logic         is_reg;

    // Only one transaction in flight, write wins a tie with read
    assign wr_accept = (state == SL_IDLE) && awvalid && wvalid;
    assign rd_accept = (state == SL_IDLE) && arvalid && !(awvalid && wvalid);
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign arready   = rd_accept;

    // Decode
    assign acc_addr = wr_accept ? awaddr : araddr;
    assign is_mem   = (acc_addr < 12'h100) &&
                      (acc_addr[`FF_AXI_ADDR_W-1:2] < `FF_MEM_DEPTH);
    assign is_ctrl  = (acc_addr == `FF_REG_CTRL);
    assign is_reg   = is_ctrl || (acc_addr == `FF_REG_STATUS) || (acc_addr == `FF_REG_GOOD);

    // Ctrl reads as zero
    always_comb begin
        reg_rdata = '0;
        if (acc_addr == `FF_REG_STATUS) begin
            reg_rdata = {30'd0, done, busy};
        end else if (acc_addr == `FF_REG_GOOD) begin
            reg_rdata = goodness;
        end
    end

    // Start pulse in the accept cycle; ignored while a pass runs
    assign start = wr_accept && is_ctrl && wdata[0] && !busy;

    // Arbiter side
    assign mem_req   = (state == SL_MEM);
    assign mem_we    = we_q;
    assign mem_addr  = addr_q[$bits(ff_word_addr_t)+1:2];
    assign mem_wdata = wdata_q;

    // Bus responses
    assign bresp = resp_q;
    assign rresp = resp_q;
    assign rdata = rdata_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= SL_IDLE;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            we_q   <= 1'b0;
        end else begin
            case (state)
                SL_IDLE: begin
                    if (wr_accept || rd_accept) begin
                        we_q <= wr_accept;
                        // Registers and errors answer on the next cycle
                        if (is_mem) begin
                            state <= SL_MEM;
                        end else begin
                            bvalid <= wr_accept;
                            rvalid <= rd_accept;
                            state  <= SL_RESP;
                        end
                    end
                end
                SL_MEM: begin
                    // Hold request until granted
                    if (mem_gnt) begin
                        bvalid <= we_q;
                        state  <= we_q ? SL_RESP : SL_MEM_DATA;
                    end
                end
                SL_MEM_DATA: begin
                    rvalid <= 1'b1;
                    state  <= SL_RESP;
                end
                SL_RESP: begin
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                        state  <= SL_IDLE;
                    end
                end
                default: state <= SL_IDLE;
            endcase
        end
    end

    // Captured request and response payload
    always_ff @(posedge clk) begin
        if (wr_accept || rd_accept) begin
            addr_q  <= acc_addr;
            wdata_q <= wdata;
            rdata_q <= reg_rdata;
            resp_q  <= (is_mem || is_reg) ? RESP_OKAY : RESP_SLVERR;
        end else if (state == SL_MEM_DATA) begin
            // Arbiter read data is valid here
            rdata_q <= mem_rdata;
        end
    end

endmodule

//--- logic/ff_mem_arbiter.sv
// Shared word memory behind a two-way round-robin arbiter
// Requester 0 is the bus slave, requester 1 the layer engine
// Read data registered per requester
`include "ff_macros.svh"

module ff_mem_arbiter import ff_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic [1:0]    req,
    input  logic [1:0]    we,
    input  ff_word_addr_t addr [2],
    input  ff_data_t      wdata [2],
    output logic [1:0]    gnt,
    output ff_data_t      rdata [2]
);

    ff_data_t mem [`FF_MEM_DEPTH];
    logic     last_win;
    logic     sel;

    // Grant in the request cycle, loser of the last contest wins a tie
    always_comb begin
        gnt = req;
        if (&req) begin
            gnt          = 2'b00;
            gnt[~last_win] = 1'b1;
        end
    end

    // Index of the granted requester
    assign sel = gnt[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_win <= 1'b0;
            for (int k = 0; k < `FF_MEM_DEPTH; k++) begin
                mem[k] <= '0;
            end
        end else if (|gnt) begin
            last_win <= sel;
            if (we[sel]) begin
                mem[addr[sel]] <= wdata[sel];
            end
        end
    end

    // Read data stays until the requester's next read grant
    always_ff @(posedge clk) begin
        for (int r = 0; r < 2; r++) begin
            if (gnt[r] && !we[r]) begin
                rdata[r] <= mem[addr[r]];
            end
        end
    end

endmodule

//--- logic/ff_layer_engine.sv
// Forward pass of one fully connected layer
// Per neuron: MAC over input and weight pairs, bias, ReLU, write back
// All operands fetched through the arbiter, two cycles per access
`include "ff_macros.svh"

module ff_layer_engine import ff_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    output logic          busy,
    output logic          done,
    output logic          mem_req,
    output logic          mem_we,
    output ff_word_addr_t mem_addr,
    output ff_data_t      mem_wdata,
    input  logic          mem_gnt,
    input  ff_data_t      mem_rdata,
    output logic          act_valid,
    output logic          clear,
    output ff_data_t      act_data
);

    localparam int IN_W  = $clog2(`FF_INPUTS);
    localparam int NEU_W = $clog2(`FF_NEURONS);

    ff_engine_state_t   state;
    logic               pending;
    logic               start_ok;
    logic [IN_W-1:0]    in_idx;
    logic [NEU_W-1:0]   neu_idx;
    ff_data_t           in_q;
    ff_data_t           sum_q;
    ff_data_t           act_q;
    ff_data_t           term;
    ff_data_t           pre_act;
    logic signed [63:0] prod;

    assign busy     = (state != IDLE) && (state != DONE);
    assign done     = (state == DONE);
    assign start_ok = start && !busy;
    assign clear    = start_ok;

    // Request until granted, then one cycle for the read data
    assign mem_req   = busy && !pending;
    assign mem_we    = (state == WRITE_ACT);
    assign mem_wdata = act_q;

    // Activation reported as it is written
    assign act_valid = mem_req && mem_gnt && mem_we;
    assign act_data  = act_q;

    always_comb begin
        case (state)
            READ_IN:   mem_addr = ff_word_addr_t'(`FF_IN_BASE + in_idx);
            READ_W:    mem_addr = ff_word_addr_t'(`FF_W_BASE + neu_idx * `FF_INPUTS + in_idx);
            READ_BIAS: mem_addr = ff_word_addr_t'(`FF_BIAS_BASE + neu_idx);
            default:   mem_addr = ff_word_addr_t'(`FF_ACT_BASE + neu_idx);
        endcase
    end

    // Full signed product back to Q16.16, low 32 bits kept
    assign prod    = $signed(in_q) * $signed(mem_rdata);
    assign term    = ff_data_t'(prod >>> `FF_FRAC_BITS);
    assign pre_act = sum_q + mem_rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            pending <= 1'b0;
            in_idx  <= '0;
            neu_idx <= '0;
        end else if (start_ok) begin
            state   <= READ_IN;
            pending <= 1'b0;
            in_idx  <= '0;
            neu_idx <= '0;
        end else if (mem_req && mem_gnt) begin
            pending <= 1'b1;
        end else if (pending) begin
            pending <= 1'b0;
            case (state)
                READ_IN: state <= READ_W;
                READ_W: begin
                    if (in_idx == IN_W'(`FF_INPUTS - 1)) begin
                        in_idx <= '0;
                        state  <= READ_BIAS;
                    end else begin
                        in_idx <= in_idx + 1'b1;
                        state  <= READ_IN;
                    end
                end
                READ_BIAS: state <= WRITE_ACT;
                WRITE_ACT: begin
                    // Last neuron ends the pass, done holds until next start
                    if (neu_idx == NEU_W'(`FF_NEURONS - 1)) begin
                        state <= DONE;
                    end else begin
                        neu_idx <= neu_idx + 1'b1;
                        state   <= READ_IN;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Datapath, loaded in the cycle the read data arrives
    always_ff @(posedge clk) begin
        if (start_ok) begin
            sum_q <= '0;
        end else if (pending) begin
            case (state)
                READ_IN:   in_q  <= mem_rdata;
                READ_W:    sum_q <= sum_q + term;
                // ReLU on the biased sum
                READ_BIAS: act_q <= pre_act[31] ? '0 : pre_act;
                WRITE_ACT: sum_q <= '0;
                default:   sum_q <= sum_q;
            endcase
        end
    end

endmodule

//--- logic/ff_goodness_accum.sv
// Goodness of one pass
// Sum of squared activations, each square back in Q16.16
`include "ff_macros.svh"

module ff_goodness_accum import ff_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clear,
    input  logic     act_valid,
    input  ff_data_t act_data,
    output ff_data_t goodness
);

    logic signed [63:0] sq;

    // Square at full width
    assign sq = $signed(act_data) * $signed(act_data);

    // Wrapping 32-bit sum, one term per reported activation
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            goodness <= '0;
        end else if (clear) begin
            // New pass
            goodness <= '0;
        end else if (act_valid) begin
            goodness <= goodness + ff_data_t'(sq >>> `FF_FRAC_BITS);
        end
    end

endmodule

//--- logic/ff_layer_top.sv
// Top of the forward-forward layer
// AXI4-Lite slave and layer engine share one memory through the arbiter
// Goodness accumulator fed by the engine

module ff_layer_top import ff_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  ff_axi_addr_t awaddr,
    input  logic         awvalid,
    output logic         awready,
    input  ff_data_t     wdata,
    input  logic [3:0]   wstrb,
    input  logic         wvalid,
    output logic         wready,
    output ff_resp_t     bresp,
    output logic         bvalid,
    input  logic         bready,
    input  ff_axi_addr_t araddr,
    input  logic         arvalid,
    output logic         arready,
    output ff_data_t     rdata,
    output ff_resp_t     rresp,
    output logic         rvalid,
    input  logic         rready
);

    // Arbiter ports, index 0 slave, index 1 engine
    logic [1:0]    arb_req;
    logic [1:0]    arb_we;
    logic [1:0]    arb_gnt;
    ff_word_addr_t arb_addr [2];
    ff_data_t      arb_wdata [2];
    ff_data_t      arb_rdata [2];

    // Engine control and results
    logic          start;
    logic          busy;
    logic          done;
    logic          act_valid;
    logic          acc_clear;
    ff_data_t      act_data;
    ff_data_t      goodness;

    ff_axil_slave ff_axil_slave_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .mem_req   (arb_req[0]),
        .mem_we    (arb_we[0]),
        .mem_addr  (arb_addr[0]),
        .mem_wdata (arb_wdata[0]),
        .mem_gnt   (arb_gnt[0]),
        .mem_rdata (arb_rdata[0]),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .goodness  (goodness)
    );

    ff_mem_arbiter ff_mem_arbiter_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (arb_req),
        .we    (arb_we),
        .addr  (arb_addr),
        .wdata (arb_wdata),
        .gnt   (arb_gnt),
        .rdata (arb_rdata)
    );

    ff_layer_engine ff_layer_engine_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .mem_req   (arb_req[1]),
        .mem_we    (arb_we[1]),
        .mem_addr  (arb_addr[1]),
        .mem_wdata (arb_wdata[1]),
        .mem_gnt   (arb_gnt[1]),
        .mem_rdata (arb_rdata[1]),
        .act_valid (act_valid),
        .clear     (acc_clear),
        .act_data  (act_data)
    );

    ff_goodness_accum ff_goodness_accum_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (acc_clear),
        .act_valid (act_valid),
        .act_data  (act_data),
        .goodness  (goodness)
    );

endmodule

//--- testbench/tb_ff_layer.sv
// Testbench of the forward-forward layer top
// LFSR stimulus, AXI4-Lite read and write tasks
// Reference model of activations and goodness
// Compare tasks per result type, watchdog
`include "ff_macros.svh"

module tb_ff_layer import ff_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS = 6;
    localparam int WATCHDOG_CYCLES =
        NUM_TESTS * 4 * `FF_NEURONS * (2 * `FF_INPUTS + 2) * 4 + 2000;
    // -1000.0, far below any reachable MAC sum
    localparam ff_data_t NEG_BIAS = 32'hFC18_0000;

    logic         clk;
    logic         rst_n;
    ff_axi_addr_t awaddr;
    logic         awvalid;
    logic         awready;
    ff_data_t     wdata;
    logic [3:0]   wstrb;
    logic         wvalid;
    logic         wready;
    ff_resp_t     bresp;
    logic         bvalid;
    logic         bready;
    ff_axi_addr_t araddr;
    logic         arvalid;
    logic         arready;
    ff_data_t     rdata;
    ff_resp_t     rresp;
    logic         rvalid;
    logic         rready;

    // Expected contents of the shared memory
    ff_data_t    mirror [`FF_MEM_DEPTH];
    ff_data_t    model_good;
    logic [31:0] lfsr;
    int          error_count;
    int          check_count;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;

    ff_layer_top ff_layer_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Ends a run that stops making progress
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog: the run timed out before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // Signed Q16.16 with magnitude below 4.0
    function automatic ff_data_t rand_value();
        logic [31:0] mag;
        logic        neg;
        mag = rand_bits(18);
        neg = (rand_bits(1) != 0);
        return neg ? -mag : mag;
    endfunction

    // Layer model on the mirror, activations written back into it
    function automatic void run_model();
        ff_data_t           sum;
        ff_data_t           pre;
        ff_data_t           act;
        logic signed [63:0] prod;
        model_good = '0;
        for (int n = 0; n < `FF_NEURONS; n++) begin
            sum = '0;
            for (int i = 0; i < `FF_INPUTS; i++) begin
                prod = $signed(mirror[`FF_IN_BASE + i]) *
                       $signed(mirror[`FF_W_BASE + n * `FF_INPUTS + i]);
                sum  = sum + ff_data_t'(prod >>> `FF_FRAC_BITS);
            end
            pre = sum + mirror[`FF_BIAS_BASE + n];
            // ReLU
            act = pre[31] ? '0 : pre;
            mirror[`FF_ACT_BASE + n] = act;
            prod       = $signed(act) * $signed(act);
            model_good = model_good + ff_data_t'(prod >>> `FF_FRAC_BITS);
        end
    endfunction

    task automatic check_data(input string name, input ff_data_t expected,
                              input ff_data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_resp(input string name, input ff_resp_t expected,
                              input ff_resp_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Address and data together, then wait for the response
    task automatic axi_write(input ff_axi_addr_t addr, input ff_data_t data,
                             output ff_resp_t resp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        #1;
        while (!(awready && wready)) begin
            @(negedge clk);
            #1;
        end
        // Both channels accepted at the coming posedge
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        #1;
        while (!bvalid) begin
            @(negedge clk);
            #1;
        end
        resp = bresp;
        // bready held high
        @(posedge clk);
    endtask

    task automatic axi_read(input ff_axi_addr_t addr, output ff_data_t data,
                            output ff_resp_t resp);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid = 1'b0;
        #1;
        while (!rvalid) begin
            @(negedge clk);
            #1;
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
    endtask

    task automatic write_word(input string name, input int idx, input ff_data_t data);
        ff_resp_t resp;
        axi_write(ff_axi_addr_t'(idx * 4), data, resp);
        check_resp($sformatf("%s write resp word %0d", name, idx), RESP_OKAY, resp);
        mirror[idx] = data;
    endtask

    // Compared with the mirror
    task automatic read_word(input string name, input int idx);
        ff_resp_t resp;
        ff_data_t data;
        axi_read(ff_axi_addr_t'(idx * 4), data, resp);
        check_resp($sformatf("%s read resp word %0d", name, idx), RESP_OKAY, resp);
        check_data($sformatf("%s word %0d", name, idx), mirror[idx], data);
    endtask

    // Random inputs, weights and biases
    task automatic load_layer(input string name, input logic neg_bias);
        for (int i = 0; i < `FF_INPUTS; i++) begin
            write_word(name, `FF_IN_BASE + i, rand_value());
        end
        for (int w = 0; w < `FF_NEURONS * `FF_INPUTS; w++) begin
            write_word(name, `FF_W_BASE + w, rand_value());
        end
        for (int n = 0; n < `FF_NEURONS; n++) begin
            write_word(name, `FF_BIAS_BASE + n, neg_bias ? NEG_BIAS : rand_value());
        end
    endtask

    // Start, then expect busy alone in the status
    task automatic start_pass(input string name);
        ff_resp_t resp;
        ff_data_t status;
        axi_write(`FF_REG_CTRL, 32'h1, resp);
        check_resp({name, " start resp"}, RESP_OKAY, resp);
        axi_read(`FF_REG_STATUS, status, resp);
        check_resp({name, " status resp"}, RESP_OKAY, resp);
        check_data({name, " status busy"}, 32'h1, status);
    endtask

    // Poll until done, then expect done alone
    task automatic wait_done(input string name);
        ff_resp_t resp;
        ff_data_t status;
        status = '0;
        while (!status[1]) begin
            axi_read(`FF_REG_STATUS, status, resp);
            check_resp({name, " poll resp"}, RESP_OKAY, resp);
        end
        check_data({name, " status done"}, 32'h2, status);
    endtask

    task automatic check_acts(input string name);
        for (int n = 0; n < `FF_NEURONS; n++) begin
            read_word({name, " act"}, `FF_ACT_BASE + n);
        end
    endtask

    task automatic check_good(input string name, input ff_data_t expected);
        ff_resp_t resp;
        ff_data_t good;
        axi_read(`FF_REG_GOOD, good, resp);
        check_resp({name, " goodness resp"}, RESP_OKAY, resp);
        check_data({name, " goodness"}, expected, good);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name,
                     error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    initial begin
        int       idx_list [16];
        ff_resp_t resp;
        ff_data_t data;
        awaddr          = '0;
        awvalid         = 1'b0;
        wdata           = '0;
        wstrb           = 4'hF;
        wvalid          = 1'b0;
        bready          = 1'b1;
        araddr          = '0;
        arvalid         = 1'b0;
        rready          = 1'b1;
        rst_n           = 1'b0;
        lfsr            = 32'h6c70_0c3e;
        model_good      = '0;
        error_count     = 0;
        check_count     = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        // Memory comes out of reset cleared
        for (int k = 0; k < `FF_MEM_DEPTH; k++) begin
            mirror[k] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Random words at random addresses
        for (int k = 0; k < 16; k++) begin
            idx_list[k] = int'(rand_bits($clog2(`FF_MEM_DEPTH)));
            write_word("mem_readback", idx_list[k], rand_value());
        end
        for (int k = 0; k < 16; k++) begin
            read_word("mem_readback", idx_list[k]);
        end
        end_test("mem_readback");

        load_layer("forward_pass", 1'b0);
        start_pass("forward_pass");
        wait_done("forward_pass");
        run_model();
        check_acts("forward_pass");
        end_test("forward_pass");

        // All neurons clamp to zero
        load_layer("negative_bias", 1'b1);
        start_pass("negative_bias");
        wait_done("negative_bias");
        run_model();
        check_acts("negative_bias");
        check_good("negative_bias", 32'h0);
        end_test("negative_bias");

        for (int p = 0; p < 3; p++) begin
            load_layer("goodness", 1'b0);
            start_pass("goodness");
            wait_done("goodness");
            run_model();
            check_good($sformatf("goodness pass %0d", p), model_good);
        end
        end_test("goodness");

        // Slave competes with the engine for the memory
        load_layer("read_during_pass", 1'b0);
        start_pass("read_during_pass");
        for (int k = 0; k < 8; k++) begin
            read_word("read_during_pass",
                      `FF_W_BASE + int'(rand_bits($clog2(`FF_NEURONS * `FF_INPUTS))));
        end
        wait_done("read_during_pass");
        run_model();
        check_acts("read_during_pass");
        end_test("read_during_pass");

        // Unmapped addresses, nothing may change
        axi_write(12'h10C, 32'hFFFF_FFFF, resp);
        check_resp("unmapped write 0x10c", RESP_SLVERR, resp);
        axi_write(12'h200, rand_value(), resp);
        check_resp("unmapped write 0x200", RESP_SLVERR, resp);
        axi_read(12'h204, data, resp);
        check_resp("unmapped read 0x204", RESP_SLVERR, resp);
        axi_read(12'hFFC, data, resp);
        check_resp("unmapped read 0xffc", RESP_SLVERR, resp);
        axi_read(`FF_REG_STATUS, data, resp);
        check_resp("unmapped status resp", RESP_OKAY, resp);
        check_data("unmapped status", 32'h2, data);
        check_good("unmapped", model_good);
        for (int k = 0; k < `FF_MEM_DEPTH; k++) begin
            read_word("unmapped", k);
        end
        end_test("unmapped");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+logic
logic/ff_pkg.sv
logic/ff_axil_slave.sv
logic/ff_mem_arbiter.sv
logic/ff_layer_engine.sv
logic/ff_goodness_accum.sv
logic/ff_layer_top.sv
testbench/tb_ff_layer.sv

//--- Bender.yml
package:
  name: ff_layer

sources:
  - include_dirs:
      - logic
    files:
      - logic/ff_pkg.sv
      - logic/ff_axil_slave.sv
      - logic/ff_mem_arbiter.sv
      - logic/ff_layer_engine.sv
      - logic/ff_goodness_accum.sv
      - logic/ff_layer_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_ff_layer.sv
